// File: audioIsland.f
+incdir+dv
hdl/islandPkg.sv
hdl/packetBus.sv
hdl/sampleGatherer.sv
hdl/audioPacketBuilder.sv
hdl/packetSerializer.sv
hdl/islandSequencer.sv
hdl/hBlankAudioIsland.sv
dv/hBlankAudioIslandTb.sv

// File: dv/islandModel.svh
`ifndef islandModelSvh
`define islandModelSvh

// Samples the current island should carry, in FIFO order
audioSample_t expectedSamples [4];
int expectedReads;
// Both packets of the current island with the parity byte on top of each block
logic [31:0] headerBits [2];
logic [63:0] subpacketBits [2][4];
// Samples sent since the last Audio Clock Regeneration packet
int regenSamples;

function automatic tmdsWord_t terc4Word(input terc4Nibble_t nibble);
    case (nibble)
        4'h0: return 10'b1010011100;
        4'h1: return 10'b1001100011;
        4'h2: return 10'b1011100100;
        4'h3: return 10'b1011100010;
        4'h4: return 10'b0101110001;
        4'h5: return 10'b0100011110;
        4'h6: return 10'b0110001110;
        4'h7: return 10'b0100111100;
        4'h8: return 10'b1011001100;
        4'h9: return 10'b0100111001;
        4'hA: return 10'b0110011100;
        4'hB: return 10'b1011000110;
        4'hC: return 10'b1010001110;
        4'hD: return 10'b1001110001;
        4'hE: return 10'b0101100011;
        default: return 10'b1011000011;
    endcase
endfunction

// Inverse of the TERC4 table, zero for a word outside it
function automatic terc4Nibble_t terc4Decode(input tmdsWord_t word);
    for (int i = 0; i < 16; i++) begin
        if (terc4Word(terc4Nibble_t'(i)) == word) begin
            return terc4Nibble_t'(i);
        end
    end
    return 4'h0;
endfunction

function automatic tmdsWord_t controlWord(input logic [1:0] control);
    case (control)
        2'b00: return 10'b1101010100;
        2'b01: return 10'b0010101011;
        2'b10: return 10'b0101010100;
        default: return 10'b1010101011;
    endcase
endfunction

// Generator 1+x^6+x^7+x^8 written out per register stage, data fed LSB first
function automatic logic [7:0] bchParity(input logic [55:0] data, input int bitCount);
    logic [7:0] state;
    logic feedback;
    state = 8'h00;
    for (int i = 0; i < bitCount; i++) begin
        feedback = data[i] ^ state[0];
        state = {feedback, state[7:3], state[2] ^ feedback, state[1] ^ feedback};
    end
    return state;
endfunction

// Each 16-bit sample sits in the upper two bytes of its 24-bit field
function automatic subpacket_t sampleSubpacket(input audioSample_t word);
    logic [15:0] left;
    logic [15:0] right;
    logic [7:0] statusByte;
    left = word[15:0];
    right = word[31:16];
    // Only the two even parity bits of byte 6 can be set
    statusByte = {^right, 3'b000, ^left, 3'b000};
    return {statusByte, right[15:8], right[7:0], 8'h00, left[15:8], left[7:0], 8'h00};
endfunction

// Byte 0 is zero, bytes 1 to 3 carry CTS and bytes 4 to 6 carry N, high byte first
function automatic subpacket_t regenSubpacket(input acrValue_t nValue, input acrValue_t ctsValue);
    logic [23:0] ctsBytes;
    logic [23:0] nBytes;
    subpacket_t body;
    ctsBytes = 24'(ctsValue);
    nBytes = 24'(nValue);
    body = '0;
    // Byte b + 1 holds CTS byte 2 - b and byte b + 4 holds N byte 2 - b
    for (int b = 0; b < 3; b++) begin
        body[8 * (b + 1) +: 8] = ctsBytes[8 * (2 - b) +: 8];
        body[8 * (b + 4) +: 8] = nBytes[8 * (2 - b) +: 8];
    end
    return body;
endfunction

// Builds both packets and moves the regeneration count on by one island
task automatic prepareIsland(input acrValue_t nValue, input acrValue_t ctsValue,
                             input regenCount_t perRegen);
    header_t header;
    subpacket_t body;
    logic [3:0] present;
    for (int i = 0; i < 4; i++) begin
        present[i] = i < expectedReads;
    end
    header = {8'h00, 4'h0, present, 8'h02};
    headerBits[0] = {bchParity(header, 24), header};
    for (int i = 0; i < 4; i++) begin
        body = present[i] ? sampleSubpacket(expectedSamples[i]) : '0;
        subpacketBits[0][i] = {bchParity(body, 56), body};
    end
    regenSamples = regenSamples + expectedReads;
    // The second packet is a Null packet until enough samples have gone out
    header = '0;
    body = '0;
    if (regenSamples >= perRegen) begin
        regenSamples = regenSamples - perRegen;
        header = 24'h000001;
        body = regenSubpacket(nValue, ctsValue);
    end
    headerBits[1] = {bchParity(header, 24), header};
    for (int i = 0; i < 4; i++) begin
        subpacketBits[1][i] = {bchParity(body, 56), body};
    end
endtask

// Expected outputs for one counter position and the sync levels sampled with it
task automatic islandWords(input int position, input logic v, input logic h,
                           output logic active, output tmdsWord_t word0,
                           output tmdsWord_t word1, output tmdsWord_t word2);
    int packet;
    int k;
    terc4Nibble_t lane1;
    terc4Nibble_t lane2;
    active = (position >= preambleStart) && (position < islandFinished);
    word0 = '0;
    word1 = '0;
    word2 = '0;
    if (position >= preambleStart && position < leadGuardStart) begin
        word0 = controlWord({v, h});
        word1 = controlWord(2'b01);
        word2 = controlWord(2'b01);
    end else if ((position >= leadGuardStart && position < samplePacketStart)
                 || (position >= trailGuardStart && position < islandFinished)) begin
        word0 = terc4Word({2'b11, v, h});
        word1 = 10'b0100110011;
        word2 = 10'b0100110011;
    end else if (position >= samplePacketStart && position < trailGuardStart) begin
        packet = (position < regenPacketStart) ? 0 : 1;
        k = position - ((packet == 0) ? samplePacketStart : regenPacketStart);
        for (int i = 0; i < 4; i++) begin
            lane1[i] = subpacketBits[packet][i][2 * k];
            lane2[i] = subpacketBits[packet][i][2 * k + 1];
        end
        // Bit 3 drops only on the opening character of the island's first packet
        word0 = terc4Word({!(packet == 0 && k == 0), headerBits[packet][k], v, h});
        word1 = terc4Word(lane1);
        word2 = terc4Word(lane2);
    end
endtask

`endif

// File: dv/hBlankAudioIslandTb.sv
`timescale 1ns/1ps

module hBlankAudioIslandTb;
    import islandPkg::*;

    localparam int lineCount = 40;
    // 40 lines of at most 200 cycles, plus reset and a margin
    localparam int timeoutCycles = 10000;

    logic pixelClock;
    logic reset;
    logic hSync;
    logic vSync;
    logic syncIsActiveLow;
    acrValue_t n;
    acrValue_t cts;
    regenCount_t samplesPerRegenPacket;
    logic sampleFifoEmpty;
    audioSample_t sampleFifoReadData;
    logic sampleFifoReadEnable;
    logic dataIslandActive;
    tmdsWord_t channel0;
    tmdsWord_t channel1;
    tmdsWord_t channel2;

    // FIFO model contents, oldest word first
    audioSample_t fifoWords [$];
    // Read enable as seen at the last falling edge
    logic readPending;
    int readsSeen;
    // Words the DUT took from the FIFO in the current island
    audioSample_t consumedWords [4];
    // Subpacket bits decoded from the lanes of the sample packet
    logic [63:0] shownBits [4];
    // Counter position that the words now on the channels belong to
    int shownPosition;
    int wordErrors;
    int flagErrors;
    int sampleErrors;
    int otherErrors;
    int cycleCount;
    // Island timing of the reference model
    logic modelArmed;
    int position;
    logic checksEnabled;
    logic expectActive;
    tmdsWord_t expect0;
    tmdsWord_t expect1;
    tmdsWord_t expect2;

    `include "islandModel.svh"

    hBlankAudioIsland u_dut (.*);

    initial pixelClock = 1'b0;
    always #50 pixelClock = ~pixelClock;

    task automatic checkWord(input tmdsWord_t actual, input tmdsWord_t expected, input string what);
        if (actual !== expected) begin
            wordErrors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic checkFlag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            flagErrors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic checkSample(input audioSample_t actual, input audioSample_t expected,
                               input string what);
        if (actual !== expected) begin
            sampleErrors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Rebuilds the sample subpackets from the lane words the DUT sent
    task automatic recordSampleCharacter(input int k);
        terc4Nibble_t lane1;
        terc4Nibble_t lane2;
        lane1 = terc4Decode(channel1);
        lane2 = terc4Decode(channel2);
        for (int i = 0; i < 4; i++) begin
            shownBits[i][2 * k] = lane1[i];
            shownBits[i][2 * k + 1] = lane2[i];
        end
    endtask

    // Left sits in bits 23:8 and right in bits 47:32 of each sample subpacket
    task automatic compareSamples();
        for (int i = 0; i < readsSeen && i < expectedReads; i++) begin
            checkSample({shownBits[i][47:32], shownBits[i][23:8]}, consumedWords[i],
                        $sformatf("sample %0d of the packet", i));
        end
    endtask

    // One clock of stimulus, with the FIFO answering a read pulse one cycle later
    task automatic runCycle(input logic hSyncLevel);
        audioSample_t word;
        @(posedge pixelClock);
        if (readPending) begin
            if (fifoWords.size() == 0) begin
                otherErrors++;
                $display("Error at %0t ns: the DUT read from an empty FIFO", $time);
            end else begin
                word = fifoWords.pop_front();
                sampleFifoReadData <= word;
                if (readsSeen < expectedReads) begin
                    consumedWords[readsSeen] = word;
                end else begin
                    otherErrors++;
                    $display("Error at %0t ns: more FIFO reads than words available", $time);
                end
                readsSeen++;
            end
        end
        hSync <= hSyncLevel;
        sampleFifoEmpty <= (fifoWords.size() == 0);
    endtask

    // One blanking interval with a single hSync pulse and fresh line settings
    task automatic runLine();
        logic polarity;
        int leadCycles;
        int pulseCycles;
        int tailCycles;
        polarity = 1'($urandom_range(1, 0));
        leadCycles = $urandom_range(15, 8);
        pulseCycles = $urandom_range(47, 8);
        tailCycles = $urandom_range(200, 120) - leadCycles - pulseCycles;
        repeat ($urandom_range(2, 0)) fifoWords.push_back($urandom());
        // Polarity and hSync change together so the line opens inactive
        runCycle(polarity);
        syncIsActiveLow <= polarity;
        vSync <= 1'($urandom_range(1, 0));
        n <= acrValue_t'($urandom());
        cts <= acrValue_t'($urandom());
        samplesPerRegenPacket <= regenCount_t'($urandom_range(8, 2));
        repeat (leadCycles - 1) runCycle(polarity);
        repeat (pulseCycles) runCycle(!polarity);
        repeat (tailCycles) runCycle(polarity);
    endtask

    // The model steps on the falling edge where outputs and driven inputs are settled
    always @(negedge pixelClock) begin
        if (checksEnabled) begin
            checkFlag(dataIslandActive, expectActive, "dataIslandActive");
            checkWord(channel0, expect0, "channel0");
            checkWord(channel1, expect1, "channel1");
            checkWord(channel2, expect2, "channel2");
            if (shownPosition >= samplePacketStart && shownPosition < regenPacketStart) begin
                recordSampleCharacter(shownPosition - samplePacketStart);
            end
            if (shownPosition == regenPacketStart - 1) begin
                compareSamples();
            end
        end
        checksEnabled = 1'b1;
        readPending = sampleFifoReadEnable;
        shownPosition = position;
        // Outputs after the next edge come from the counter before it and the inputs it samples
        islandWords(position, vSync, hSync, expectActive, expect0, expect1, expect2);
        if (position == islandFinished - 1 && readsSeen != expectedReads) begin
            otherErrors++;
            $display("Error at %0t ns: island read %0d FIFO words instead of %0d",
                     $time, readsSeen, expectedReads);
        end
        if (reset) begin
            modelArmed = 1'b0;
            position = islandFinished;
        end else if (modelArmed && (hSync != syncIsActiveLow)) begin
            // The next edge starts an island that gathers up to four words
            modelArmed = 1'b0;
            position = 0;
            expectedReads = (fifoWords.size() < 4) ? fifoWords.size() : 4;
            for (int i = 0; i < expectedReads; i++) begin
                expectedSamples[i] = fifoWords[i];
            end
            readsSeen = 0;
            prepareIsland(n, cts, samplesPerRegenPacket);
        end else begin
            if (hSync == syncIsActiveLow) begin
                modelArmed = 1'b1;
            end
            if (position < islandFinished) begin
                position++;
            end
        end
    end

    always @(posedge pixelClock) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not end within %0d cycles", timeoutCycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h76e7));
        reset = 1'b1;
        hSync = 1'b0;
        vSync = 1'b0;
        syncIsActiveLow = 1'b0;
        n = '0;
        cts = '0;
        samplesPerRegenPacket = 8'd2;
        sampleFifoEmpty = 1'b1;
        sampleFifoReadData = '0;
        readPending = 1'b0;
        readsSeen = 0;
        shownPosition = islandFinished;
        wordErrors = 0;
        flagErrors = 0;
        sampleErrors = 0;
        otherErrors = 0;
        cycleCount = 0;
        modelArmed = 1'b0;
        position = islandFinished;
        checksEnabled = 1'b0;
        expectActive = 1'b0;
        expect0 = '0;
        expect1 = '0;
        expect2 = '0;
        expectedReads = 0;
        regenSamples = 0;
        // A few words up front so that early lines gather all four samples
        repeat (6) fifoWords.push_back($urandom());
        repeat (10) runCycle(1'b0);
        reset <= 1'b0;
        for (int line = 0; line < lineCount; line++) begin
            runLine();
        end
        repeat (2) runCycle(hSync);
        $display("Errors: %0d word, %0d flag, %0d sample, %0d other",
                 wordErrors, flagErrors, sampleErrors, otherErrors);
        if (wordErrors + flagErrors + sampleErrors + otherErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/hBlankAudioIsland.sv
`timescale 1ns/1ps

module hBlankAudioIsland (
    input  logic pixelClock,
    input  logic reset,
    input  logic hSync,
    input  logic vSync,
    input  logic syncIsActiveLow,
    input  islandPkg::acrValue_t n,
    input  islandPkg::acrValue_t cts,
    input  islandPkg::regenCount_t samplesPerRegenPacket,
    input  logic sampleFifoEmpty,
    input  islandPkg::audioSample_t sampleFifoReadData,
    output logic sampleFifoReadEnable,
    output logic dataIslandActive,
    output islandPkg::tmdsWord_t channel0,
    output islandPkg::tmdsWord_t channel1,
    output islandPkg::tmdsWord_t channel2
);
    import islandPkg::*;

    // Timing strobes from the sequencer
    logic gatherWindow;
    logic packetStart;
    logic firstPacket;
    logic islandDone;
    // Samples waiting for the next Audio Sample packet
    audioSample_t latchedSamples [maxLatchedSamples];
    sampleCount_t latchedCount;
    logic sampleCaptured;
    terc4Nibble_t ch0Nibble;
    terc4Nibble_t ch1Nibble;
    terc4Nibble_t ch2Nibble;

    packetBus packetLink ();

    islandSequencer sequencer (
        .pixelClock(pixelClock),
        .reset(reset),
        .hSync(hSync),
        .vSync(vSync),
        .syncIsActiveLow(syncIsActiveLow),
        .ch0Nibble(ch0Nibble),
        .ch1Nibble(ch1Nibble),
        .ch2Nibble(ch2Nibble),
        .gatherWindow(gatherWindow),
        .packetStart(packetStart),
        .firstPacket(firstPacket),
        .islandDone(islandDone),
        .dataIslandActive(dataIslandActive),
        .channel0(channel0),
        .channel1(channel1),
        .channel2(channel2)
    );

    sampleGatherer gatherer (
        .pixelClock(pixelClock),
        .reset(reset),
        .gatherWindow(gatherWindow),
        .islandDone(islandDone),
        .sampleFifoEmpty(sampleFifoEmpty),
        .sampleFifoReadData(sampleFifoReadData),
        .sampleFifoReadEnable(sampleFifoReadEnable),
        .latchedSamples(latchedSamples),
        .latchedCount(latchedCount),
        .sampleCaptured(sampleCaptured)
    );

    audioPacketBuilder builder (
        .pixelClock(pixelClock),
        .reset(reset),
        .sampleCaptured(sampleCaptured),
        .islandDone(islandDone),
        .firstPacket(firstPacket),
        .latchedSamples(latchedSamples),
        .latchedCount(latchedCount),
        .n(n),
        .cts(cts),
        .samplesPerRegenPacket(samplesPerRegenPacket),
        .bus(packetLink.builder)
    );

    packetSerializer serializer (
        .pixelClock(pixelClock),
        .reset(reset),
        .packetStart(packetStart),
        .firstPacket(firstPacket),
        .hSync(hSync),
        .vSync(vSync),
        .bus(packetLink.serializer),
        .ch0Nibble(ch0Nibble),
        .ch1Nibble(ch1Nibble),
        .ch2Nibble(ch2Nibble)
    );

endmodule

// File: hdl/islandSequencer.sv
`timescale 1ns/1ps

module islandSequencer (
    input  logic pixelClock,
    input  logic reset,
    input  logic hSync,
    input  logic vSync,
    input  logic syncIsActiveLow,
    input  islandPkg::terc4Nibble_t ch0Nibble,
    input  islandPkg::terc4Nibble_t ch1Nibble,
    input  islandPkg::terc4Nibble_t ch2Nibble,
    output logic gatherWindow,
    output logic packetStart,
    output logic firstPacket,
    output logic islandDone,
    output logic dataIslandActive,
    output islandPkg::tmdsWord_t channel0,
    output islandPkg::tmdsWord_t channel1,
    output islandPkg::tmdsWord_t channel2
);
    import islandPkg::*;

    logic hSyncActive;
    // Set by an inactive hSync, so each sync pulse starts one island
    logic hSyncArmed;
    // High from the restart until the counter has reached its rest value
    logic islandRunning;
    characterIndex_t characterCount;
    islandPhase_e phase;

    assign hSyncActive = hSync != syncIsActiveLow;

    always_ff @(posedge pixelClock) begin
        if (reset) begin
            hSyncArmed <= 1'b0;
            islandRunning <= 1'b0;
            characterCount <= islandFinished;
        end else if (hSyncArmed && hSyncActive) begin
            hSyncArmed <= 1'b0;
            islandRunning <= 1'b1;
            characterCount <= '0;
        end else begin
            if (!hSyncActive) begin
                hSyncArmed <= 1'b1;
            end
            if (characterCount < islandFinished) begin
                characterCount <= characterCount + 1'b1;
            end else begin
                islandRunning <= 1'b0;
            end
        end
    end

    always_comb begin
        if (characterCount < preambleStart) begin
            phase = phaseGather;
        end else if (characterCount < leadGuardStart) begin
            phase = phasePreamble;
        end else if (characterCount < samplePacketStart) begin
            phase = phaseLeadGuard;
        end else if (characterCount < trailGuardStart) begin
            phase = phasePacket;
        end else if (characterCount < islandFinished) begin
            phase = phaseTrailGuard;
        end else begin
            phase = phaseDone;
        end
    end

    assign gatherWindow = phase == phaseGather;
    assign packetStart = (characterCount == samplePacketStart)
        || (characterCount == regenPacketStart);
    assign firstPacket = characterCount < regenPacketStart;
    // The counter rests at islandFinished, so the running flag limits this to one cycle
    assign islandDone = islandRunning && (characterCount == islandFinished);

    // Encoded words are registered, so they trail the counter by one cycle
    always_ff @(posedge pixelClock) begin
        if (reset) begin
            dataIslandActive <= 1'b0;
            channel0 <= '0;
            channel1 <= '0;
            channel2 <= '0;
        end else begin
            dataIslandActive <= (phase != phaseGather) && (phase != phaseDone);
            case (phase)
                phasePreamble: begin
                    // Lanes 1 and 2 announce a data island with CTL 01
                    channel0 <= ctlEncode({vSync, hSync});
                    channel1 <= ctlEncode(2'b01);
                    channel2 <= ctlEncode(2'b01);
                end
                phaseLeadGuard, phaseTrailGuard: begin
                    channel0 <= terc4Encode({2'b11, vSync, hSync});
                    channel1 <= guardBandWord;
                    channel2 <= guardBandWord;
                end
                phasePacket: begin
                    channel0 <= terc4Encode(ch0Nibble);
                    channel1 <= terc4Encode(ch1Nibble);
                    channel2 <= terc4Encode(ch2Nibble);
                end
                default: begin
                    channel0 <= '0;
                    channel1 <= '0;
                    channel2 <= '0;
                end
            endcase
        end
    end

    // The active flag follows the counter by one cycle through the island
    assert property (@(posedge pixelClock) disable iff (reset)
        dataIslandActive |-> (characterCount > preambleStart)
            && (characterCount <= islandFinished));

endmodule

// File: hdl/packetSerializer.sv
`timescale 1ns/1ps

module packetSerializer (
    input  logic pixelClock,
    input  logic reset,
    input  logic packetStart,
    input  logic firstPacket,
    input  logic hSync,
    input  logic vSync,
    packetBus.serializer bus,
    output islandPkg::terc4Nibble_t ch0Nibble,
    output islandPkg::terc4Nibble_t ch1Nibble,
    output islandPkg::terc4Nibble_t ch2Nibble
);
    import islandPkg::*;

    // Character within the current packet, valid after the start cycle
    logic [4:0] characterIndex;
    // Header and subpackets with their parity bytes on top
    logic [31:0] headerBits;
    logic [63:0] subpacketBits [4];
    logic headerBit;
    logic [3:0] evenBits;
    logic [3:0] oddBits;
    logic firstCharacter;

    always_ff @(posedge pixelClock) begin
        if (reset) begin
            characterIndex <= '0;
        end else if (packetStart) begin
            // Character 0 went out straight from the bus
            characterIndex <= 5'd1;
        end else begin
            characterIndex <= characterIndex + 1'b1;
        end
    end

    always_ff @(posedge pixelClock) begin
        if (packetStart) begin
            headerBits <= {bchParity8(bus.header, $bits(header_t)), bus.header};
            subpacketBits[0] <= {bchParity8(bus.subpacket0, $bits(subpacket_t)), bus.subpacket0};
            subpacketBits[1] <= {bchParity8(bus.subpacket1, $bits(subpacket_t)), bus.subpacket1};
            subpacketBits[2] <= {bchParity8(bus.subpacket2, $bits(subpacket_t)), bus.subpacket2};
            subpacketBits[3] <= {bchParity8(bus.subpacket3, $bits(subpacket_t)), bus.subpacket3};
        end
    end

    always_comb begin
        if (packetStart) begin
            // First character comes from the data bits, parity lies further up
            headerBit = bus.header[0];
            evenBits = {bus.subpacket3[0], bus.subpacket2[0], bus.subpacket1[0],
                        bus.subpacket0[0]};
            oddBits = {bus.subpacket3[1], bus.subpacket2[1], bus.subpacket1[1],
                       bus.subpacket0[1]};
        end else begin
            headerBit = headerBits[characterIndex];
            for (int i = 0; i < 4; i++) begin
                // Each character carries two bits of every subpacket
                evenBits[i] = subpacketBits[i][{characterIndex, 1'b0}];
                oddBits[i] = subpacketBits[i][{characterIndex, 1'b1}];
            end
        end
    end

    // Bit 3 of lane 0 is low only for the very first packet character of the island
    assign firstCharacter = packetStart && firstPacket;

    assign ch0Nibble = {!firstCharacter, headerBit, vSync, hSync};
    assign ch1Nibble = evenBits;
    assign ch2Nibble = oddBits;

endmodule

// File: hdl/audioPacketBuilder.sv
`timescale 1ns/1ps

module audioPacketBuilder (
    input  logic pixelClock,
    input  logic reset,
    input  logic sampleCaptured,
    input  logic islandDone,
    input  logic firstPacket,
    input  islandPkg::audioSample_t latchedSamples [islandPkg::maxLatchedSamples],
    input  islandPkg::sampleCount_t latchedCount,
    input  islandPkg::acrValue_t n,
    input  islandPkg::acrValue_t cts,
    input  islandPkg::regenCount_t samplesPerRegenPacket,
    packetBus.builder bus
);
    import islandPkg::*;

    // Samples sent since the last clock regeneration packet
    regenCount_t regenCount;
    logic regenDue;
    logic [3:0] samplePresent;
    subpacket_t sampleSubpackets [maxLatchedSamples];
    subpacket_t regenSubpacket;

    // Two 24-bit samples plus the V, U, C and P bits of each channel in byte 6
    function automatic subpacket_t makeSampleSubpacket(input audioSample_t sample);
        logic [15:0] left;
        logic [15:0] right;
        left = sample[15:0];
        right = sample[31:16];
        // Even parity covers the sample only since V, U and C are all zero
        return {^right, 3'b000, ^left, 3'b000, right, 8'h00, left, 8'h00};
    endfunction

    assign regenDue = regenCount >= samplesPerRegenPacket;

    always_ff @(posedge pixelClock) begin
        if (reset) begin
            regenCount <= '0;
        end else if (islandDone && regenDue) begin
            // A regeneration packet was just sent, keep the remainder
            regenCount <= regenCount - samplesPerRegenPacket;
        end else if (sampleCaptured) begin
            regenCount <= regenCount + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < maxLatchedSamples; i++) begin
            samplePresent[i] = latchedCount > i;
            // Subpackets with no sample behind them stay zero
            sampleSubpackets[i] = samplePresent[i] ? makeSampleSubpacket(latchedSamples[i]) : '0;
        end
    end

    // Byte 0 is zero, then CTS and N each high byte first
    assign regenSubpacket = {n[7:0], n[15:8], 4'h0, n[19:16],
                             cts[7:0], cts[15:8], 4'h0, cts[19:16], 8'h00};

    always_comb begin
        if (firstPacket) begin
            // Audio Sample packet, layout 0 and no flat samples
            bus.header = {8'h00, 4'h0, samplePresent, 8'h02};
            bus.subpacket0 = sampleSubpackets[0];
            bus.subpacket1 = sampleSubpackets[1];
            bus.subpacket2 = sampleSubpackets[2];
            bus.subpacket3 = sampleSubpackets[3];
        end else if (regenDue) begin
            // Audio Clock Regeneration packet repeats the same subpacket four times
            bus.header = 24'h000001;
            bus.subpacket0 = regenSubpacket;
            bus.subpacket1 = regenSubpacket;
            bus.subpacket2 = regenSubpacket;
            bus.subpacket3 = regenSubpacket;
        end else begin
            // Null packet
            bus.header = '0;
            bus.subpacket0 = '0;
            bus.subpacket1 = '0;
            bus.subpacket2 = '0;
            bus.subpacket3 = '0;
        end
    end

endmodule

// File: hdl/sampleGatherer.sv
`timescale 1ns/1ps

module sampleGatherer (
    input  logic pixelClock,
    input  logic reset,
    input  logic gatherWindow,
    input  logic islandDone,
    input  logic sampleFifoEmpty,
    input  islandPkg::audioSample_t sampleFifoReadData,
    output logic sampleFifoReadEnable,
    output islandPkg::audioSample_t latchedSamples [islandPkg::maxLatchedSamples],
    output islandPkg::sampleCount_t latchedCount,
    output logic sampleCaptured
);
    import islandPkg::*;

    // High in the cycle where the FIFO word is valid on sampleFifoReadData
    logic dataPending;
    logic readStart;

    // A new read only begins once the previous one has been captured
    assign readStart = gatherWindow && !sampleFifoEmpty && !sampleFifoReadEnable
        && !dataPending && (latchedCount < maxLatchedSamples);

    // The word is stored in the same cycle as it is valid
    assign sampleCaptured = dataPending;

    always_ff @(posedge pixelClock) begin
        if (reset) begin
            sampleFifoReadEnable <= 1'b0;
            dataPending <= 1'b0;
            latchedCount <= '0;
        end else if (islandDone) begin
            // The sample packet has gone out, start over for the next line
            sampleFifoReadEnable <= 1'b0;
            dataPending <= 1'b0;
            latchedCount <= '0;
        end else begin
            // Read pulse, then one cycle for the FIFO to present the word
            sampleFifoReadEnable <= readStart;
            dataPending <= sampleFifoReadEnable;
            if (dataPending) begin
                latchedCount <= latchedCount + 1'b1;
            end
        end
    end

    always_ff @(posedge pixelClock) begin
        if (islandDone) begin
            for (int i = 0; i < maxLatchedSamples; i++) begin
                latchedSamples[i] <= '0;
            end
        end else if (dataPending) begin
            latchedSamples[latchedCount[1:0]] <= sampleFifoReadData;
        end
    end

    // The FIFO must never see a read pulse while it reports empty
    assert property (@(posedge pixelClock) disable iff (reset)
        sampleFifoReadEnable |-> !sampleFifoEmpty);

endmodule

// File: hdl/packetBus.sv
`timescale 1ns/1ps

// One packet's contents on their way from the builder to the serializer
interface packetBus;
    import islandPkg::*;

    header_t header;
    subpacket_t subpacket0;
    subpacket_t subpacket1;
    subpacket_t subpacket2;
    subpacket_t subpacket3;

    // The builder drives every field combinationally
    modport builder (
        output header, subpacket0, subpacket1, subpacket2, subpacket3
    );

    // The serializer samples the fields on packet start
    modport serializer (
        input header, subpacket0, subpacket1, subpacket2, subpacket3
    );

endinterface

// File: hdl/islandPkg.sv
package islandPkg;

    // One FIFO word, right sample in the upper half and left sample in the lower half
    typedef logic [31:0] audioSample_t;
    typedef logic [2:0] sampleCount_t;
    typedef logic [7:0] regenCount_t;
    // N or CTS for audio clock regeneration
    typedef logic [19:0] acrValue_t;
    typedef logic [6:0] characterIndex_t;
    typedef logic [23:0] header_t;
    typedef logic [55:0] subpacket_t;
    typedef logic [3:0] terc4Nibble_t;
    typedef logic [9:0] tmdsWord_t;

    typedef enum logic [2:0] {
        phaseGather,
        phasePreamble,
        phaseLeadGuard,
        phasePacket,
        phaseTrailGuard,
        phaseDone
    } islandPhase_e;

    // Character counts at which each part of the island begins
    localparam characterIndex_t preambleStart = 7'd16;
    localparam characterIndex_t leadGuardStart = 7'd24;
    localparam characterIndex_t samplePacketStart = 7'd26;
    localparam characterIndex_t regenPacketStart = 7'd58;
    localparam characterIndex_t trailGuardStart = 7'd90;
    localparam characterIndex_t islandFinished = 7'd92;

    localparam sampleCount_t maxLatchedSamples = 3'd4;
    localparam int packetCharacters = 32;

    // Lanes 1 and 2 send this fixed word in both guard bands
    localparam tmdsWord_t guardBandWord = 10'b0100110011;

    function automatic tmdsWord_t terc4Encode(input terc4Nibble_t nibble);
        case (nibble)
            4'h0: return 10'b1010011100;
            4'h1: return 10'b1001100011;
            4'h2: return 10'b1011100100;
            4'h3: return 10'b1011100010;
            4'h4: return 10'b0101110001;
            4'h5: return 10'b0100011110;
            4'h6: return 10'b0110001110;
            4'h7: return 10'b0100111100;
            4'h8: return 10'b1011001100;
            4'h9: return 10'b0100111001;
            4'hA: return 10'b0110011100;
            4'hB: return 10'b1011000110;
            4'hC: return 10'b1010001110;
            4'hD: return 10'b1001110001;
            4'hE: return 10'b0101100011;
            default: return 10'b1011000011;
        endcase
    endfunction

    function automatic tmdsWord_t ctlEncode(input logic [1:0] control);
        case (control)
            2'b00: return 10'b1101010100;
            2'b01: return 10'b0010101011;
            2'b10: return 10'b0101010100;
            default: return 10'b1010101011;
        endcase
    endfunction

    // BCH(64,56) and BCH(32,24) share the generator 1+x^6+x^7+x^8, fed LSB first
    function automatic logic [7:0] bchParity8(input subpacket_t data, input int bitCount);
        logic [7:0] parity;
        logic feedback;
        parity = 8'd0;
        for (int i = 0; i < $bits(subpacket_t); i++) begin
            if (i < bitCount) begin
                feedback = parity[0] ^ data[i];
                parity = (parity >> 1) ^ (feedback ? 8'b1000_0011 : 8'd0);
            end
        end
        return parity;
    endfunction

endpackage
